//--- logic/vid_regs_pkg.sv
`default_nettype none

// Register map of the video controller and the widths tied to it
package vid_regs_pkg;

  localparam int data_width      = 16; // Register and bus data width
  localparam int tile_ctrl_width = 8;  // Implemented bits of REG_TILE_CTRL

  // Returned by REG_ID, reads as ASCII "VC"
  localparam logic [data_width-1:0] id_value = 16'h5643;

  // Register addresses
  typedef enum int unsigned {
    REG_ID        = 0, // RO, identity constant
    REG_STATUS    = 1, // RO, bit 0 vblank, bit 1 scan enable
    REG_SCAN_X    = 2, // RO, live horizontal position
    REG_SCAN_Y    = 3, // RO, live vertical position
    REG_SYS_CTRL  = 4, // RW, bit 0 enables scanning
    REG_SCROLL_X  = 5, // RW
    REG_SCROLL_Y  = 6, // RW
    REG_TILE_CTRL = 7  // RW, low byte only
  } reg_addr_e;

  typedef enum logic {
    REG_RW,
    REG_RO
  } reg_kind_e;

  // Kind of register at an address
  // Anything not listed as read/write is treated as read-only
  function automatic reg_kind_e reg_kind_of(input int unsigned addr);
    case (addr)
      REG_SYS_CTRL,
      REG_SCROLL_X,
      REG_SCROLL_Y,
      REG_TILE_CTRL: return REG_RW;
      default:       return REG_RO; // ID, status, scan position, holes
    endcase
  endfunction

endpackage

`default_nettype wire

//--- logic/vid_bus_pkg.sv
`default_nettype none

// Register bus shared by the host and debug masters
package vid_bus_pkg;

  localparam int addr_width = 4; // Word address, 16 locations

  // Bus opcodes
  typedef enum logic {
    BUS_READ,
    BUS_WRITE
  } bus_op_e;

  // Byte enable is fixed at 2 bits for the 16-bit bus

endpackage

`default_nettype wire

//--- logic/reg_bus_arbiter.sv
`default_nettype none

// Two masters, one register bus
// Each port queues one request, grants alternate when both are waiting
module reg_bus_arbiter (
  input  wire logic                                  clk,
  input  wire logic                                  rst_n,
  input  wire logic                                  host_req,
  input  wire vid_bus_pkg::bus_op_e                  host_op,
  input  wire logic [vid_bus_pkg::addr_width-1:0]    host_addr,
  input  wire logic [1:0]                            host_be,
  input  wire logic [vid_regs_pkg::data_width-1:0]   host_wdata,
  output logic                                       host_ack,
  output logic [vid_regs_pkg::data_width-1:0]        host_rdata,
  input  wire logic                                  dbg_req,
  input  wire vid_bus_pkg::bus_op_e                  dbg_op,
  input  wire logic [vid_bus_pkg::addr_width-1:0]    dbg_addr,
  input  wire logic [1:0]                            dbg_be,
  input  wire logic [vid_regs_pkg::data_width-1:0]   dbg_wdata,
  output logic                                       dbg_ack,
  output logic [vid_regs_pkg::data_width-1:0]        dbg_rdata,
  output logic                                       acc_stb,
  output vid_bus_pkg::bus_op_e                       acc_op,
  output logic [vid_bus_pkg::addr_width-1:0]         acc_addr,
  output logic [1:0]                                 acc_be,
  output logic [vid_regs_pkg::data_width-1:0]        acc_wdata,
  input  wire logic [vid_regs_pkg::data_width-1:0]   rsp_rdata
);

  typedef enum logic {
    ARB_IDLE,     // Bus free
    ARB_WAIT_RSP  // Access issued, response due this cycle
  } arb_state_e;

  arb_state_e state;

  logic host_pend, dbg_pend; // One-entry request slots
  logic last_dbg;            // Last grant went to debug, so it owns the access in flight
  logic grant_dbg;           // Debug wins this cycle

  // Slot payload, captured on req
  vid_bus_pkg::bus_op_e                 host_op_q, dbg_op_q;
  logic [vid_bus_pkg::addr_width-1:0]   host_addr_q, dbg_addr_q;
  logic [1:0]                           host_be_q, dbg_be_q;
  logic [vid_regs_pkg::data_width-1:0]  host_wdata_q, dbg_wdata_q;

  always_ff @(posedge clk) begin
    if (host_req) begin
      host_op_q    <= host_op;
      host_addr_q  <= host_addr;
      host_be_q    <= host_be;
      host_wdata_q <= host_wdata;
    end
    if (dbg_req) begin
      dbg_op_q    <= dbg_op;
      dbg_addr_q  <= dbg_addr;
      dbg_be_q    <= dbg_be;
      dbg_wdata_q <= dbg_wdata;
    end
  end

  // Debug goes if alone, or if host had the previous turn
  assign grant_dbg = dbg_pend && (!host_pend || !last_dbg);
  assign acc_stb   = (state == ARB_IDLE) && (host_pend || dbg_pend);

  assign acc_op    = grant_dbg ? dbg_op_q    : host_op_q;
  assign acc_addr  = grant_dbg ? dbg_addr_q  : host_addr_q;
  assign acc_be    = grant_dbg ? dbg_be_q    : host_be_q;
  assign acc_wdata = grant_dbg ? dbg_wdata_q : host_wdata_q;

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      state     <= ARB_IDLE;
      host_pend <= 1'b0;
      dbg_pend  <= 1'b0;
      last_dbg  <= 1'b0;
    end else begin
      // New request wins over the clear, slot is free again once granted
      if (host_req)                   host_pend <= 1'b1;
      else if (acc_stb && !grant_dbg) host_pend <= 1'b0;
      if (dbg_req)                    dbg_pend  <= 1'b1;
      else if (acc_stb && grant_dbg)  dbg_pend  <= 1'b0;

      case (state)
        ARB_IDLE: begin
          if (acc_stb) begin
            state    <= ARB_WAIT_RSP;
            last_dbg <= grant_dbg;
          end
        end
        ARB_WAIT_RSP: state <= ARB_IDLE; // Response lands now, bus frees next cycle
      endcase
    end
  end

  // Response goes back to whoever owns the access
  assign host_ack   = (state == ARB_WAIT_RSP) && !last_dbg;
  assign dbg_ack    = (state == ARB_WAIT_RSP) && last_dbg;
  assign host_rdata = host_ack ? rsp_rdata : '0;
  assign dbg_rdata  = dbg_ack  ? rsp_rdata : '0; // Write responses are already zero

endmodule

`default_nettype wire

//--- logic/ctrl_reg_file.sv
`default_nettype none

// Control and status registers on the internal access bus
module ctrl_reg_file (
  input  wire logic                                       clk,
  input  wire logic                                       rst_n,
  input  wire logic                                       acc_stb,
  input  wire vid_bus_pkg::bus_op_e                       acc_op,
  input  wire logic [vid_bus_pkg::addr_width-1:0]         acc_addr,
  input  wire logic [1:0]                                 acc_be,
  input  wire logic [vid_regs_pkg::data_width-1:0]        acc_wdata,
  output logic [vid_regs_pkg::data_width-1:0]             rsp_rdata,
  input  wire logic [vid_regs_pkg::data_width-1:0]        scan_x,
  input  wire logic [vid_regs_pkg::data_width-1:0]        scan_y,
  input  wire logic                                       vblank,
  output logic                                            scan_en,
  output logic [vid_regs_pkg::data_width-1:0]             scroll_x,
  output logic [vid_regs_pkg::data_width-1:0]             scroll_y,
  output logic [vid_regs_pkg::tile_ctrl_width-1:0]        tile_ctrl
);

  localparam int dw = vid_regs_pkg::data_width;
  localparam int tw = vid_regs_pkg::tile_ctrl_width;

  // Read/write storage
  logic [dw-1:0] sys_ctrl_q;
  logic [dw-1:0] scroll_x_q;
  logic [dw-1:0] scroll_y_q;
  logic [tw-1:0] tile_ctrl_q; // Upper bits not implemented

  int unsigned   addr_u;    // Address widened for the map compare
  logic [dw-1:0] rd_data;   // Current value at acc_addr
  logic [dw-1:0] wr_merged; // rd_data with enabled bytes replaced
  logic          wr_en;

  assign addr_u = 32'(acc_addr);

  // Read mux, also the base for byte merging
  always_comb begin
    case (addr_u)
      vid_regs_pkg::REG_ID:        rd_data = vid_regs_pkg::id_value;
      vid_regs_pkg::REG_STATUS:    rd_data = {{(dw-2){1'b0}}, sys_ctrl_q[0], vblank};
      vid_regs_pkg::REG_SCAN_X:    rd_data = scan_x;       // Live position
      vid_regs_pkg::REG_SCAN_Y:    rd_data = scan_y;
      vid_regs_pkg::REG_SYS_CTRL:  rd_data = sys_ctrl_q;
      vid_regs_pkg::REG_SCROLL_X:  rd_data = scroll_x_q;
      vid_regs_pkg::REG_SCROLL_Y:  rd_data = scroll_y_q;
      vid_regs_pkg::REG_TILE_CTRL: rd_data = {{(dw-tw){1'b0}}, tile_ctrl_q};
      default:                     rd_data = '0; // Holes read zero
    endcase
  end

  // Byte lanes, low byte 7..0 and high byte 15..8
  always_comb begin
    wr_merged = rd_data;
    if (acc_be[0]) wr_merged[7:0]  = acc_wdata[7:0];
    if (acc_be[1]) wr_merged[15:8] = acc_wdata[15:8];
  end

  // RO and unmapped addresses drop the write
  assign wr_en = acc_stb && (acc_op == vid_bus_pkg::BUS_WRITE) &&
                 (vid_regs_pkg::reg_kind_of(addr_u) == vid_regs_pkg::REG_RW);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      sys_ctrl_q  <= '0;
      scroll_x_q  <= '0;
      scroll_y_q  <= '0;
      tile_ctrl_q <= '0;
    end else if (wr_en) begin
      case (addr_u)
        vid_regs_pkg::REG_SYS_CTRL:  sys_ctrl_q  <= wr_merged;
        vid_regs_pkg::REG_SCROLL_X:  scroll_x_q  <= wr_merged;
        vid_regs_pkg::REG_SCROLL_Y:  scroll_y_q  <= wr_merged;
        vid_regs_pkg::REG_TILE_CTRL: tile_ctrl_q <= wr_merged[tw-1:0]; // Drop high byte
        default: ;
      endcase
    end
  end

  // Response one cycle after the strobe, zero unless a read
  always_ff @(posedge clk) begin
    if (acc_stb && (acc_op == vid_bus_pkg::BUS_READ))
      rsp_rdata <= rd_data;
    else
      rsp_rdata <= '0;
  end

  assign scan_en   = sys_ctrl_q[0];
  assign scroll_x  = scroll_x_q;   // To the tile fetch
  assign scroll_y  = scroll_y_q;
  assign tile_ctrl = tile_ctrl_q;

endmodule

`default_nettype wire

//--- logic/raster_scan_counter.sv
`default_nettype none

// Raster position, x in the inner loop and y on each x wrap
module raster_scan_counter #(
  parameter int h_total  = 10, // Pixels per line, blanking included
  parameter int v_total  = 6,  // Lines per frame, blanking included
  parameter int v_active = 4   // Visible lines
) (
  input  wire logic                                clk,
  input  wire logic                                rst_n,
  input  wire logic                                scan_en,
  output logic [vid_regs_pkg::data_width-1:0]      scan_x,
  output logic [vid_regs_pkg::data_width-1:0]      scan_y,
  output logic                                     vblank
);

  localparam int dw = vid_regs_pkg::data_width;

  localparam logic [dw-1:0] x_last = dw'(h_total - 1);
  localparam logic [dw-1:0] y_last = dw'(v_total - 1);

  logic x_wrap; // Last pixel of the line

  assign x_wrap = (scan_x == x_last);

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      scan_x <= '0;
      scan_y <= '0;
    end else if (scan_en) begin // Hold position while disabled
      scan_x <= x_wrap ? '0 : scan_x + 1'b1;
      if (x_wrap) begin
        scan_y <= (scan_y == y_last) ? '0 : scan_y + 1'b1;
      end
    end
  end

  // Blanking covers the lines below the visible area
  assign vblank = (scan_y >= dw'(v_active));

endmodule

`default_nettype wire

//--- logic/vid_ctrl_top.sv
`default_nettype none

// Control register subsystem of the video controller
module vid_ctrl_top #(
  parameter int h_total  = 10,
  parameter int v_total  = 6,
  parameter int v_active = 4
) (
  input  wire logic                                     clk,
  input  wire logic                                     rst_n,
  // Host CPU port
  input  wire logic                                     host_req,
  input  wire vid_bus_pkg::bus_op_e                     host_op,
  input  wire logic [vid_bus_pkg::addr_width-1:0]       host_addr,
  input  wire logic [1:0]                               host_be,
  input  wire logic [vid_regs_pkg::data_width-1:0]      host_wdata,
  output logic                                          host_ack,
  output logic [vid_regs_pkg::data_width-1:0]           host_rdata,
  // Debug port
  input  wire logic                                     dbg_req,
  input  wire vid_bus_pkg::bus_op_e                     dbg_op,
  input  wire logic [vid_bus_pkg::addr_width-1:0]       dbg_addr,
  input  wire logic [1:0]                               dbg_be,
  input  wire logic [vid_regs_pkg::data_width-1:0]      dbg_wdata,
  output logic                                          dbg_ack,
  output logic [vid_regs_pkg::data_width-1:0]           dbg_rdata,
  // Rendering pipeline controls
  output logic [vid_regs_pkg::data_width-1:0]           scroll_x,
  output logic [vid_regs_pkg::data_width-1:0]           scroll_y,
  output logic [vid_regs_pkg::tile_ctrl_width-1:0]      tile_ctrl
);

  // Arbiter to register file
  logic                                   acc_stb;
  vid_bus_pkg::bus_op_e                   acc_op;
  logic [vid_bus_pkg::addr_width-1:0]     acc_addr;
  logic [1:0]                             acc_be;
  logic [vid_regs_pkg::data_width-1:0]    acc_wdata;
  logic [vid_regs_pkg::data_width-1:0]    rsp_rdata;

  // Scan counter and register file
  logic                                   scan_en;
  logic [vid_regs_pkg::data_width-1:0]    scan_x, scan_y;
  logic                                   vblank;

  reg_bus_arbiter u_arb (
    .clk, .rst_n,
    .host_req, .host_op, .host_addr, .host_be, .host_wdata, .host_ack, .host_rdata,
    .dbg_req, .dbg_op, .dbg_addr, .dbg_be, .dbg_wdata, .dbg_ack, .dbg_rdata,
    .acc_stb, .acc_op, .acc_addr, .acc_be, .acc_wdata,
    .rsp_rdata
  );

  ctrl_reg_file u_regs (
    .clk, .rst_n,
    .acc_stb, .acc_op, .acc_addr, .acc_be, .acc_wdata,
    .rsp_rdata,
    .scan_x, .scan_y, .vblank,
    .scan_en, .scroll_x, .scroll_y, .tile_ctrl
  );

  raster_scan_counter #(
    .h_total  (h_total),
    .v_total  (v_total),
    .v_active (v_active)
  ) u_scan (
    .clk, .rst_n,
    .scan_en,
    .scan_x, .scan_y, .vblank
  );

endmodule

`default_nettype wire

//--- verification/vid_ctrl_assert.sv
`default_nettype none

// Handshake and bus rules, bound into reg_bus_arbiter
module vid_ctrl_assert (
  input wire logic clk,
  input wire logic rst_n,
  input wire logic host_ack,
  input wire logic dbg_ack,
  input wire logic acc_stb
);

  timeunit 1ns;
  timeprecision 100ps;

  int fail_count = 0; // Read by the testbench top at the end

  ack_host_single: assert property (@(posedge clk) disable iff (!rst_n) host_ack |=> !host_ack)
    else begin $error("host_ack held longer than one cycle"); fail_count++; end

  ack_dbg_single: assert property (@(posedge clk) disable iff (!rst_n) dbg_ack |=> !dbg_ack)
    else begin $error("dbg_ack held longer than one cycle"); fail_count++; end

  ack_exclusive: assert property (@(posedge clk) disable iff (!rst_n) !(host_ack && dbg_ack))
    else begin $error("host_ack and dbg_ack in the same cycle"); fail_count++; end

  stb_spaced: assert property (@(posedge clk) disable iff (!rst_n) acc_stb |=> !acc_stb)
    else begin $error("acc_stb high in two consecutive cycles"); fail_count++; end

endmodule

`default_nettype wire

//--- verification/vid_ctrl_checker.sv
`default_nettype none

// Watches both master ports, models the RW registers and checks every read
module vid_ctrl_checker #(
  parameter int h_total  = 10,
  parameter int v_total  = 6,
  parameter int v_active = 4
) (
  input wire logic                 clk,
  input wire logic                 rst_n,
  input wire logic                 host_req,
  input wire vid_bus_pkg::bus_op_e host_op,
  input wire logic [3:0]           host_addr,
  input wire logic [1:0]           host_be,
  input wire logic [15:0]          host_wdata,
  input wire logic                 host_ack,
  input wire logic [15:0]          host_rdata,
  input wire logic                 dbg_req,
  input wire vid_bus_pkg::bus_op_e dbg_op,
  input wire logic [3:0]           dbg_addr,
  input wire logic [1:0]           dbg_be,
  input wire logic [15:0]          dbg_wdata,
  input wire logic                 dbg_ack,
  input wire logic [15:0]          dbg_rdata,
  input wire logic [15:0]          scroll_x,
  input wire logic [15:0]          scroll_y,
  input wire logic [7:0]           tile_ctrl
);

  timeunit 1ns;
  timeprecision 100ps;

  int errors = 0;
  int reads  = 0;
  int cyc    = 0;

  logic [15:0] model [16];       // Only addresses 4..7 ever change
  logic [15:0] last_x, last_y;   // Scan position seen while frozen
  logic        x_valid, y_valid;
  // Per port, index 0 host and 1 debug
  logic        outst [2];
  logic        contested [2];
  int          req_cyc [2];
  logic        is_wr [2];
  logic [3:0]  addr_q [2];
  logic [1:0]  be_q [2];
  logic [15:0] wdata_q [2];
  logic        fixed [2];
  logic [15:0] fixed_val [2];
  logic        exp_set [2];      // Table value waiting for the next request
  logic [15:0] exp_next [2];

  logic [1:0]  req_v, ack_v;
  logic [15:0] rdata_v [2];
  assign req_v = {dbg_req, host_req};
  assign ack_v = {dbg_ack, host_ack};
  assign rdata_v[0] = host_rdata;
  assign rdata_v[1] = dbg_rdata;

  function automatic string pname(int p);
    return (p == 1) ? "dbg" : "host";
  endfunction

  // Expected value of a non-scan address
  function automatic logic [15:0] model_value(int a);
    case (a)
      0:       return 16'h5643;             // Identity "VC"
      4, 5, 6: return model[a];
      7:       return {8'h00, model[7][7:0]}; // Tile control is 8 bits
      default: return 16'h0000;             // Holes
    endcase
  endfunction

  task automatic expect_value(input int p, input logic [15:0] v);
    exp_set[p]  = 1'b1;
    exp_next[p] = v;
  endtask

  task automatic apply_write(input int a, input logic [1:0] be, input logic [15:0] wd);
    if (a >= 4 && a <= 7) begin
      if (be[0]) model[a][7:0]  = wd[7:0];
      if (be[1]) model[a][15:8] = wd[15:8];
      if (a == 7) model[7][15:8] = 8'h00;
      if (a == 4) begin // Scan state restarts from here
        x_valid = 1'b0;
        y_valid = 1'b0;
      end
    end
  endtask

  task automatic bad(input int p, input int a, input logic [15:0] got, input logic [15:0] exp);
    $display("[FAIL] %s_rdata addr %h: got %h, expected %h", pname(p), a[3:0], got, exp);
    errors++;
  endtask

  task automatic check_read(input int p, input int a, input logic [15:0] rd);
    logic en;
    en = model[4][0];
    reads++;
    if (fixed[p]) begin
      if (rd !== fixed_val[p]) bad(p, a, rd, fixed_val[p]);
    end else if (a == 2) begin
      if (rd >= h_total) bad(p, a, rd, 16'(h_total - 1));
      if (!en && x_valid && rd !== last_x) bad(p, a, rd, last_x); // Frozen
      if (!en) begin
        last_x  = rd;
        x_valid = 1'b1;
      end
    end else if (a == 3) begin
      if (rd >= v_total) bad(p, a, rd, 16'(v_total - 1));
      if (!en && y_valid && rd !== last_y) bad(p, a, rd, last_y);
      last_y  = rd;
      y_valid = !en;
    end else if (a == 1) begin
      if (rd[1] !== en || rd[15:2] !== 14'h0)
        bad(p, a, rd, {14'h0, en, rd[0]});
      if (!en && y_valid && rd[0] !== (last_y >= v_active))
        bad(p, a, rd, {14'h0, en, last_y >= v_active});
    end else if (rd !== model_value(a)) begin
      bad(p, a, rd, model_value(a));
    end
  endtask

  // Pipeline outputs must follow the RW registers
  task automatic check_outputs();
    if (scroll_x !== model[5]) begin
      $display("[FAIL] scroll_x got %h expected %h", scroll_x, model[5]);
      errors++;
    end
    if (scroll_y !== model[6]) begin
      $display("[FAIL] scroll_y got %h expected %h", scroll_y, model[6]);
      errors++;
    end
    if (tile_ctrl !== model[7][7:0]) begin
      $display("[FAIL] tile_ctrl got %h expected %h", tile_ctrl, model[7][7:0]);
      errors++;
    end
  endtask

  task automatic report();
    $display("checker: %0d errors, %0d reads checked", errors, reads);
  endtask

  always @(posedge clk) begin
    cyc++;
    if (!rst_n) begin
      foreach (model[a]) model[a] = 16'h0;
      last_x  = 16'h0; // Counters reset to zero and stay there
      last_y  = 16'h0;
      x_valid = 1'b1;
      y_valid = 1'b1;
      for (int p = 0; p < 2; p++) begin
        outst[p]   = 1'b0;
        fixed[p]   = 1'b0;
        exp_set[p] = 1'b0;
      end
    end else begin
      for (int p = 0; p < 2; p++) begin // Acks first, in order of arrival
        if (ack_v[p]) begin
          if (!outst[p]) begin
            $display("%s port gave an ack with no request outstanding", pname(p));
            errors++;
          end else begin
            if (!contested[p] && cyc - req_cyc[p] != 2) begin
              $display("%s ack came %0d cycles after req instead of 2",
                       pname(p), cyc - req_cyc[p]);
              errors++;
            end
            if (is_wr[p]) begin
              apply_write(addr_q[p], be_q[p], wdata_q[p]);
              if (rdata_v[p] !== 16'h0) bad(p, addr_q[p], rdata_v[p], 16'h0);
            end else begin
              check_read(p, addr_q[p], rdata_v[p]);
            end
          end
          outst[p] = 1'b0;
        end else if (outst[p] && cyc - req_cyc[p] > 40) begin
          $display("%s request to addr %h was never acked", pname(p), addr_q[p]);
          errors++;
          outst[p] = 1'b0;
        end
      end
      for (int p = 0; p < 2; p++) begin
        if (req_v[p]) begin
          outst[p]     = 1'b1;
          req_cyc[p]   = cyc;
          contested[p] = outst[1-p] || req_v[1-p];
          is_wr[p]     = (p == 1) ? (dbg_op == vid_bus_pkg::BUS_WRITE)
                                  : (host_op == vid_bus_pkg::BUS_WRITE);
          addr_q[p]    = (p == 1) ? dbg_addr  : host_addr;
          be_q[p]      = (p == 1) ? dbg_be    : host_be;
          wdata_q[p]   = (p == 1) ? dbg_wdata : host_wdata;
          fixed[p]     = exp_set[p];
          fixed_val[p] = exp_next[p];
          exp_set[p]   = 1'b0;
        end else if (outst[p] && req_v[1-p]) begin
          contested[p] = 1'b1; // Other master joined the queue
        end
      end
    end
  end

endmodule

`default_nettype wire

//--- verification/vid_ctrl_tb.sv
`default_nettype none

module vid_ctrl_tb;

  timeunit 1ns;
  timeprecision 100ps;

  localparam int h_total  = 10;
  localparam int v_total  = 6;
  localparam int v_active = 4;

  typedef struct {
    int                   port;  // 0 host, 1 debug
    vid_bus_pkg::bus_op_e op;
    logic [3:0]           addr;
    logic [1:0]           be;
    logic [15:0]          wdata;
    logic [15:0]          exp;
    logic                 use_model; // Checker derives the read value itself
  } entry_t;

  logic clk, rst_n;
  logic host_req, dbg_req, host_ack, dbg_ack;
  vid_bus_pkg::bus_op_e host_op, dbg_op;
  logic [3:0]  host_addr, dbg_addr;
  logic [1:0]  host_be, dbg_be;
  logic [15:0] host_wdata, dbg_wdata, host_rdata, dbg_rdata;
  logic [15:0] scroll_x, scroll_y;
  logic [7:0]  tile_ctrl;
  entry_t      table_q[$];
  logic        hung;

  vid_ctrl_top #(.h_total(h_total), .v_total(v_total), .v_active(v_active)) UUT (.*);

  vid_ctrl_checker #(.h_total(h_total), .v_total(v_total), .v_active(v_active)) chk (.*);

  bind reg_bus_arbiter vid_ctrl_assert u_assert (.clk, .rst_n, .host_ack, .dbg_ack, .acc_stb);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  task automatic add(input int p, input vid_bus_pkg::bus_op_e op, input logic [3:0] a,
                     input logic [1:0] be, input logic [15:0] wd, input logic [15:0] exp,
                     input logic use_model);
    entry_t e;
    e = '{p, op, a, be, wd, exp, use_model};
    table_q.push_back(e);
  endtask

  // Drives one port's request signals for the current cycle
  task automatic drive(input entry_t e);
    if (e.port == 0) begin
      host_req   = 1'b1;
      host_op    = e.op;
      host_addr  = e.addr;
      host_be    = e.be;
      host_wdata = e.wdata;
    end else begin
      dbg_req   = 1'b1;
      dbg_op    = e.op;
      dbg_addr  = e.addr;
      dbg_be    = e.be;
      dbg_wdata = e.wdata;
    end
    if (e.op == vid_bus_pkg::BUS_READ && !e.use_model) chk.expect_value(e.port, e.exp);
  endtask

  // Waits until every port in mask has acked, or gives up
  task automatic wait_acks(input logic [1:0] mask);
    logic [1:0] seen;
    int         n;
    seen = 2'b00;
    n    = 0;
    @(posedge clk);
    #1;
    host_req = 1'b0;
    dbg_req  = 1'b0;
    while ((seen & mask) != mask && n < 30) begin
      @(posedge clk);
      #1;
      seen |= {dbg_ack, host_ack};
      n++;
    end
    if ((seen & mask) != mask) begin
      $display("timed out waiting for an ack, mask %b seen %b", mask, seen);
      hung = 1'b1;
    end
  endtask

  initial begin
    void'($urandom(32'hdea51088));
    hung       = 1'b0;
    rst_n      = 1'b0;
    host_req   = 1'b0;
    host_op    = vid_bus_pkg::BUS_READ;
    host_addr  = '0;
    host_be    = '0;
    host_wdata = '0;
    dbg_req    = 1'b0;
    dbg_op     = vid_bus_pkg::BUS_READ;
    dbg_addr   = '0;
    dbg_be     = '0;
    dbg_wdata  = '0;

    for (int a = 0; a < 8; a++) add(0, vid_bus_pkg::BUS_READ, a, 2'b11, 0, 0, 1); // Reset values
    add(0, vid_bus_pkg::BUS_WRITE, 5, 2'b11, 16'h1234, 0, 1);
    add(1, vid_bus_pkg::BUS_WRITE, 5, 2'b01, 16'hffab, 0, 1);  // Low byte only
    add(0, vid_bus_pkg::BUS_READ,  5, 2'b11, 0, 16'h12ab, 0);
    add(0, vid_bus_pkg::BUS_WRITE, 7, 2'b11, 16'hbeef, 0, 1);
    add(1, vid_bus_pkg::BUS_READ,  7, 2'b11, 0, 16'h00ef, 0);
    add(1, vid_bus_pkg::BUS_WRITE, 6, 2'b10, 16'h5a77, 0, 1);
    add(0, vid_bus_pkg::BUS_READ,  6, 2'b11, 0, 16'h5a00, 0);
    add(0, vid_bus_pkg::BUS_WRITE, 0, 2'b11, 16'hffff, 0, 1);  // RO drops it
    add(0, vid_bus_pkg::BUS_READ,  0, 2'b11, 0, vid_regs_pkg::id_value, 0);
    add(1, vid_bus_pkg::BUS_WRITE, 9, 2'b11, 16'hffff, 0, 1);  // Hole
    add(1, vid_bus_pkg::BUS_READ,  9, 2'b11, 0, 16'h0000, 0);
    add(1, vid_bus_pkg::BUS_WRITE, 4, 2'b01, 16'h0001, 0, 1);  // Scan on
    for (int a = 1; a < 4; a++) add(0, vid_bus_pkg::BUS_READ, a, 2'b11, 0, 0, 1);
    // Keep scanning until the frame is down in the blanking lines
    for (int i = 0; i < 20; i++) add(i % 2, vid_bus_pkg::BUS_READ, 2 + i % 2, 2'b11, 0, 0, 1);
    add(0, vid_bus_pkg::BUS_WRITE, 4, 2'b11, 16'h0000, 0, 1);  // Scan off
    add(0, vid_bus_pkg::BUS_READ,  2, 2'b11, 0, 0, 1);
    add(1, vid_bus_pkg::BUS_READ,  2, 2'b11, 0, 0, 1);
    add(0, vid_bus_pkg::BUS_READ,  3, 2'b11, 0, 0, 1);
    add(0, vid_bus_pkg::BUS_READ,  1, 2'b11, 0, 0, 1);

    repeat (4) @(posedge clk);
    #1 rst_n = 1'b1;
    @(posedge clk);
    #1;

    foreach (table_q[i]) begin
      drive(table_q[i]);
      wait_acks(table_q[i].port == 0 ? 2'b01 : 2'b10);
      if (hung) break;
    end

    // Both masters write in the same cycle
    for (int i = 0; i < 8 && !hung; i++) begin
      drive('{0, vid_bus_pkg::BUS_WRITE, 4'(5 + $urandom % 3), 2'($urandom % 3 + 1),
              16'($urandom), 0, 1});
      drive('{1, vid_bus_pkg::BUS_WRITE, 4'(5 + $urandom % 3), 2'($urandom % 3 + 1),
              16'($urandom), 0, 1});
      wait_acks(2'b11);
    end
    for (int a = 5; a < 8 && !hung; a++) begin
      drive('{0, vid_bus_pkg::BUS_READ, 4'(a), 2'b11, 0, 0, 1});
      wait_acks(2'b01);
    end
    chk.check_outputs();

    chk.report();
    if (!hung && chk.errors == 0 && UUT.u_arb.u_assert.fail_count == 0) begin
      $display("Test completed successfully");
    end else begin
      $display("Test failed");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sources.f
logic/vid_regs_pkg.sv
logic/vid_bus_pkg.sv
logic/reg_bus_arbiter.sv
logic/ctrl_reg_file.sv
logic/raster_scan_counter.sv
logic/vid_ctrl_top.sv
verification/vid_ctrl_assert.sv
verification/vid_ctrl_checker.sv
verification/vid_ctrl_tb.sv

//--- run_sim.sh
#!/bin/sh
# Build with Verilator, run, and judge the run by the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --assert --timing -f sources.f --top-module vid_ctrl_tb \
  -o vid_ctrl_sim > build.log 2>&1 &&
  ./obj_dir/vid_ctrl_sim > sim.log 2>&1
cat build.log sim.log 2>/dev/null
grep -q "Test completed successfully" sim.log && echo "PASS" || { echo "FAIL"; exit 1; }
